// File: Makefile
# Verilator build and run of the memory subsystem testbench

TOP := mem_subsystem_tb
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f all.f

run: compile
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "Verification passed" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// File: all.f
design/mem_pkg.sv
design/generic_bus_if.sv
design/memory_controller.sv
design/wait_state_ram.sv
design/mem_subsystem_top.sv
tb/mem_bus_checker.sv
tb/mem_subsystem_tb.sv

// File: design/generic_bus_if.sv
// generic bus
// level request bus with a busy-based wait, used between the
// memory controller and the shared RAM
`timescale 1ns/1ps

interface generic_bus_if import mem_pkg::*; ();

  // master to slave
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] wdata;
  logic              ren;
  logic              wen;
  logic [BE_W-1:0]   byte_en;

  // slave to master
  logic [DATA_W-1:0] rdata;
  logic              busy;

  // master side
  modport cpu (
    output addr, wdata, ren, wen, byte_en,
    input  rdata, busy
  );

  // slave side
  modport generic_bus (
    input  addr, wdata, ren, wen, byte_en,
    output rdata, busy
  );

endinterface

// File: design/mem_pkg.sv
// memory subsystem package
// bus widths, bus byte order, shared RAM size and timing,
// and the state encoding of the memory controller

package mem_pkg;

  // bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int BE_W   = DATA_W / 8;

  // "big" passes data through unchanged
  // "little" reverses the four bytes on write and on read
  localparam string BUS_ENDIANNESS = "big";

  // shared RAM is word addressed by addr[9:2]
  localparam int RAM_DEPTH_WORDS = 256;
  localparam int RAM_AW          = $clog2(RAM_DEPTH_WORDS);

  // busy stays high this many cycles after a request is accepted
  localparam int RAM_WAIT_CYCLES = 2;
  localparam int WAIT_CNT_W      = (RAM_WAIT_CYCLES > 1) ? $clog2(RAM_WAIT_CYCLES) : 1;

  // memory controller arbitration states
  typedef enum logic [2:0] {
    IDLE,
    INSTR_REQ,
    INSTR_WAIT,
    DATA_REQ,
    DATA_WAIT
  } arb_state_t;

endpackage

// File: design/mem_subsystem_top.sv
// memory subsystem top
// data and instruction master ports through the memory controller
// to the shared wait-state RAM
`timescale 1ns/1ps

module mem_subsystem_top import mem_pkg::*; (
  input  logic              CLK,
  input  logic              nRST,
  // data master
  input  logic [ADDR_W-1:0] i_d_addr,
  input  logic [DATA_W-1:0] i_d_wdata,
  input  logic [BE_W-1:0]   i_d_byte_en,
  input  logic              i_d_ren,
  input  logic              i_d_wen,
  output logic [DATA_W-1:0] o_d_rdata,
  output logic              o_d_busy,
  // read-only instruction master
  input  logic [ADDR_W-1:0] i_i_addr,
  input  logic              i_i_ren,
  output logic [DATA_W-1:0] o_i_rdata,
  output logic              o_i_busy
);

  generic_bus_if d_bus ();
  generic_bus_if i_bus ();
  generic_bus_if mem_bus ();

  assign d_bus.addr    = i_d_addr;
  assign d_bus.wdata   = i_d_wdata;
  assign d_bus.byte_en = i_d_byte_en;
  assign d_bus.ren     = i_d_ren;
  assign d_bus.wen     = i_d_wen;
  assign o_d_rdata     = d_bus.rdata;
  assign o_d_busy      = d_bus.busy;

  // unused write fields of the fetch port tied off
  assign i_bus.addr    = i_i_addr;
  assign i_bus.ren     = i_i_ren;
  assign i_bus.wen     = 1'b0;
  assign i_bus.wdata   = '0;
  assign i_bus.byte_en = '1;
  assign o_i_rdata     = i_bus.rdata;
  assign o_i_busy      = i_bus.busy;

  memory_controller u_ctrl (
    .CLK       (CLK),
    .nRST      (nRST),
    .i_d_bus   (d_bus.generic_bus),
    .i_i_bus   (i_bus.generic_bus),
    .o_mem_bus (mem_bus.cpu)
  );

  wait_state_ram u_ram (
    .CLK   (CLK),
    .nRST  (nRST),
    .i_bus (mem_bus.generic_bus)
  );

endmodule

// File: design/memory_controller.sv
// memory controller
// arbitrates between the data and instruction masters with data first,
// forwards the winner onto the shared bus, converts byte order and
// places sub-word write data on the lanes given by the byte enable
`timescale 1ns/1ps

module memory_controller import mem_pkg::*; (
  input logic                CLK,
  input logic                nRST,
  generic_bus_if.generic_bus i_d_bus,
  generic_bus_if.generic_bus i_i_bus,
  generic_bus_if.cpu         o_mem_bus
);

  arb_state_t state;
  arb_state_t next_state;

  logic              d_pending;
  logic              data_grant;
  logic              instr_grant;
  logic [DATA_W-1:0] d_wdata_swap;
  logic [DATA_W-1:0] d_wdata_lane;
  logic [DATA_W-1:0] rdata_swap;

  assign d_pending = i_d_bus.ren || i_d_bus.wen;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  // data port always wins when both ask in the same cycle
  always_comb begin
    next_state = state;
    case (state)
      IDLE: begin
        if (d_pending) begin
          next_state = DATA_REQ;
        end else if (i_i_bus.ren) begin
          next_state = INSTR_REQ;
        end
      end
      // ram accepts in the REQ cycle and busy shows from the next one
      INSTR_REQ: begin
        next_state = INSTR_WAIT;
      end
      INSTR_WAIT: begin
        if (!o_mem_bus.busy) begin
          next_state = IDLE;
        end
      end
      DATA_REQ: begin
        next_state = DATA_WAIT;
      end
      DATA_WAIT: begin
        if (!o_mem_bus.busy) begin
          next_state = IDLE;
        end
      end
      default: begin
        next_state = IDLE;
      end
    endcase
  end

  assign data_grant  = (state == DATA_REQ) || (state == DATA_WAIT);
  assign instr_grant = (state == INSTR_REQ) || (state == INSTR_WAIT);

  // request onto the shared bus is held for the whole transfer
  always_comb begin
    o_mem_bus.addr    = '0;
    o_mem_bus.wdata   = '0;
    o_mem_bus.ren     = 1'b0;
    o_mem_bus.wen     = 1'b0;
    o_mem_bus.byte_en = '0;
    if (data_grant) begin
      o_mem_bus.addr    = i_d_bus.addr;
      o_mem_bus.wdata   = d_wdata_lane;
      o_mem_bus.ren     = i_d_bus.ren;
      o_mem_bus.wen     = i_d_bus.wen;
      o_mem_bus.byte_en = i_d_bus.byte_en;
    end else if (instr_grant) begin
      // fetch is always a full-word read
      o_mem_bus.addr    = i_i_bus.addr;
      o_mem_bus.ren     = i_i_bus.ren;
      o_mem_bus.wen     = 1'b0;
      o_mem_bus.byte_en = '1;
    end
  end

  // only the granted master sees busy drop, and only when memory finishes
  always_comb begin
    i_d_bus.busy = 1'b1;
    i_i_bus.busy = 1'b1;
    case (state)
      DATA_WAIT: begin
        i_d_bus.busy = o_mem_bus.busy;
      end
      INSTR_WAIT: begin
        i_i_bus.busy = o_mem_bus.busy;
      end
      default: begin
        i_d_bus.busy = 1'b1;
        i_i_bus.busy = 1'b1;
      end
    endcase
  end

  // byte order conversion uses the same swap in both directions
  generate
    if (BUS_ENDIANNESS == "little") begin : g_swap
      assign d_wdata_swap = {i_d_bus.wdata[7:0], i_d_bus.wdata[15:8],
                             i_d_bus.wdata[23:16], i_d_bus.wdata[31:24]};
      assign rdata_swap   = {o_mem_bus.rdata[7:0], o_mem_bus.rdata[15:8],
                             o_mem_bus.rdata[23:16], o_mem_bus.rdata[31:24]};
    end else begin : g_pass
      assign d_wdata_swap = i_d_bus.wdata;
      assign rdata_swap   = o_mem_bus.rdata;
    end
  endgenerate

  // sub-word writes arrive in the low lanes and move up to their byte enable
  always_comb begin
    case (i_d_bus.byte_en)
      4'b0010: d_wdata_lane = d_wdata_swap << 8;
      4'b0100: d_wdata_lane = d_wdata_swap << 16;
      4'b1100: d_wdata_lane = d_wdata_swap << 16;
      4'b1000: d_wdata_lane = d_wdata_swap << 24;
      default: d_wdata_lane = d_wdata_swap;
    endcase
  end

  // read data goes back to both masters and busy tells which one owns it
  assign i_d_bus.rdata = rdata_swap;
  assign i_i_bus.rdata = rdata_swap;

endmodule

// File: design/wait_state_ram.sv
// shared wait-state RAM
// word-addressed memory with per-byte write enables that answers every
// request after a fixed number of wait cycles signalled by busy
`timescale 1ns/1ps

module wait_state_ram import mem_pkg::*; (
  input logic                CLK,
  input logic                nRST,
  generic_bus_if.generic_bus i_bus
);

  typedef enum logic [1:0] {
    RAM_IDLE,
    RAM_WAIT,
    RAM_DONE
  } ram_state_t;

  ram_state_t            state;
  logic [WAIT_CNT_W-1:0] wait_cnt;
  logic                  req;
  logic [RAM_AW-1:0]     word_idx;
  logic [DATA_W-1:0]     rdata_q;
  logic [DATA_W-1:0]     mem [RAM_DEPTH_WORDS];

  assign req = i_bus.ren || i_bus.wen;

  // upper address bits wrap onto the same words
  assign word_idx = i_bus.addr[RAM_AW+1:2];

  // accept, count the wait cycles, then one completion cycle
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state    <= RAM_IDLE;
      wait_cnt <= '0;
    end else begin
      case (state)
        RAM_IDLE: begin
          if (req) begin
            if (RAM_WAIT_CYCLES == 0) begin
              state <= RAM_DONE;
            end else begin
              state    <= RAM_WAIT;
              wait_cnt <= WAIT_CNT_W'(RAM_WAIT_CYCLES - 1);
            end
          end
        end
        RAM_WAIT: begin
          if (wait_cnt == '0) begin
            state <= RAM_DONE;
          end else begin
            wait_cnt <= wait_cnt - 1'b1;
          end
        end
        RAM_DONE: begin
          state <= RAM_IDLE;
        end
        default: begin
          state <= RAM_IDLE;
        end
      endcase
    end
  end

  // last load lands just before the completion cycle
  always_ff @(posedge CLK) begin
    if ((state == RAM_IDLE && req) || state == RAM_WAIT) begin
      rdata_q <= mem[word_idx];
    end
  end

  // writes commit at the end of the completion cycle
  always_ff @(posedge CLK) begin
    if (state == RAM_DONE && i_bus.wen) begin
      for (int b = 0; b < BE_W; b++) begin
        if (i_bus.byte_en[b]) begin
          mem[word_idx][8*b +: 8] <= i_bus.wdata[8*b +: 8];
        end
      end
    end
  end

  assign i_bus.busy  = (state == RAM_WAIT);
  assign i_bus.rdata = rdata_q;

endmodule

// File: tb/mem_bus_checker.sv
// shared bus protocol checker
// concurrent assertions on the request and busy lines of the memory controller
`timescale 1ns/1ps

module mem_bus_checker import mem_pkg::*; (
  input logic              CLK,
  input logic              nRST,
  input arb_state_t        state,
  input logic [ADDR_W-1:0] mem_addr,
  input logic              mem_ren,
  input logic              mem_wen,
  input logic              mem_busy,
  input logic              d_busy,
  input logic              i_busy
);

  int   assert_fails = 0;
  logic mem_done;

  // the granted transfer ends in a wait state once memory busy drops
  assign mem_done = ((state == DATA_WAIT) || (state == INSTR_WAIT)) && !mem_busy;

  a_single_direction: assert property (@(posedge CLK) disable iff (!nRST)
    !(mem_ren && mem_wen))
  else begin
    $error("memory ren and wen are high in the same cycle");
    assert_fails++;
  end

  // only one master may complete at a time
  a_one_master_done: assert property (@(posedge CLK) disable iff (!nRST)
    !(!d_busy && !i_busy))
  else begin
    $error("both master busy outputs are low in the same cycle");
    assert_fails++;
  end

  a_addr_stable: assert property (@(posedge CLK) disable iff (!nRST)
    ((mem_ren || mem_wen) && !mem_done) |=> $stable(mem_addr))
  else begin
    $error("memory address changed before memory busy dropped");
    assert_fails++;
  end

endmodule

bind memory_controller mem_bus_checker u_bus_checker (
  .CLK      (CLK),
  .nRST     (nRST),
  .state    (state),
  .mem_addr (o_mem_bus.addr),
  .mem_ren  (o_mem_bus.ren),
  .mem_wen  (o_mem_bus.wen),
  .mem_busy (o_mem_bus.busy),
  .d_busy   (i_d_bus.busy),
  .i_busy   (i_i_bus.busy)
);

// File: tb/mem_subsystem_tb.sv
// memory subsystem testbench
// random traffic on the data and instruction ports, checked against a
// reference memory that applies the byte order and lane placement rules
`timescale 1ns/1ps

module mem_subsystem_tb import mem_pkg::*; ();

  localparam int CLK_PERIOD  = 40;
  localparam int DRIVE_DELAY = 2;
  localparam int N_CHECK     = 16;
  localparam int N_WORD      = 24;
  localparam int N_SUB       = 32;
  localparam int N_INSTR     = 16;
  localparam int N_SAME      = 8;
  localparam int N_ARB       = 40;
  localparam int BASE_LAT    = RAM_WAIT_CYCLES + 2;
  localparam int WORST_LAT   = 2 * BASE_LAT + 2;
  localparam int TOTAL_TRANS = RAM_DEPTH_WORDS + N_CHECK + 2 * N_WORD + 2 * N_SUB
                               + N_INSTR + 2 * N_SAME + 2 * N_ARB;
  localparam int WATCHDOG_NS = TOTAL_TRANS * 4 * WORST_LAT * CLK_PERIOD;

  logic              CLK;
  logic              nRST;
  logic [ADDR_W-1:0] d_addr;
  logic [DATA_W-1:0] d_wdata;
  logic [BE_W-1:0]   d_byte_en;
  logic              d_ren;
  logic              d_wen;
  logic [DATA_W-1:0] d_rdata;
  logic              d_busy;
  logic [ADDR_W-1:0] i_addr;
  logic              i_ren;
  logic [DATA_W-1:0] i_rdata;
  logic              i_busy;

  // reference memory in bus byte order
  logic [DATA_W-1:0] model_mem [RAM_DEPTH_WORDS];
  int                seed;
  int                errors;
  int                test_start_errors;
  int                tests_passed;
  int                tests_failed;
  int                assert_errors;

  mem_subsystem_top u_dut (
    .CLK         (CLK),
    .nRST        (nRST),
    .i_d_addr    (d_addr),
    .i_d_wdata   (d_wdata),
    .i_d_byte_en (d_byte_en),
    .i_d_ren     (d_ren),
    .i_d_wen     (d_wen),
    .o_d_rdata   (d_rdata),
    .o_d_busy    (d_busy),
    .i_i_addr    (i_addr),
    .i_i_ren     (i_ren),
    .o_i_rdata   (i_rdata),
    .o_i_busy    (i_busy)
  );

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  // byte reversal between processor order and bus order
  function automatic logic [DATA_W-1:0] to_bus_order(input logic [DATA_W-1:0] w);
    logic [DATA_W-1:0] r;
    r = w;
    if (BUS_ENDIANNESS == "little") begin
      for (int i = 0; i < BE_W; i++) begin
        r[8*i +: 8] = w[8*(BE_W-1-i) +: 8];
      end
    end
    return r;
  endfunction

  // how many byte lanes sub-word data moves up
  function automatic int lane_offset(input logic [BE_W-1:0] be);
    case (be)
      4'b0010: return 1;
      4'b0100: return 2;
      4'b1100: return 2;
      4'b1000: return 3;
      default: return 0;
    endcase
  endfunction

  function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] addr);
    return (addr * 32'h9e37_79b9) ^ {addr[15:0], ~addr[15:0]};
  endfunction

  function automatic logic [DATA_W-1:0] model_read(input logic [ADDR_W-1:0] addr);
    return to_bus_order(model_mem[addr[RAM_AW+1:2]]);
  endfunction

  task automatic model_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                             input logic [BE_W-1:0] be);
    logic [DATA_W-1:0] lanes;
    lanes = to_bus_order(wdata) << (8 * lane_offset(be));
    for (int b = 0; b < BE_W; b++) begin
      if (be[b]) begin
        model_mem[addr[RAM_AW+1:2]][8*b +: 8] = lanes[8*b +: 8];
      end
    end
  endtask

  task automatic check_value(input string name, input logic [DATA_W-1:0] expected,
                             input logic [DATA_W-1:0] actual);
    if (actual !== expected) begin
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic finish_test(input string name);
    if (errors == test_start_errors) begin
      $display("test %s: ok", name);
      tests_passed++;
    end else begin
      $display("test %s: %0d errors", name, errors - test_start_errors);
      tests_failed++;
    end
    test_start_errors = errors;
  endtask

  // one data transfer with latency counted in cycles from the request
  task automatic data_access(input logic wr, input logic [ADDR_W-1:0] addr,
                             input logic [DATA_W-1:0] wdata, input logic [BE_W-1:0] be,
                             output logic [DATA_W-1:0] rdata, output int lat);
    @(posedge CLK);
    #DRIVE_DELAY;
    d_addr    = addr;
    d_wdata   = wdata;
    d_byte_en = be;
    d_ren     = !wr;
    d_wen     = wr;
    @(negedge CLK);
    lat = 0;
    while (d_busy) begin
      @(negedge CLK);
      lat++;
    end
    rdata = d_rdata;
    @(posedge CLK);
    #DRIVE_DELAY;
    d_ren = 1'b0;
    d_wen = 1'b0;
  endtask

  task automatic instr_access(input logic [ADDR_W-1:0] addr,
                              output logic [DATA_W-1:0] rdata, output int lat);
    @(posedge CLK);
    #DRIVE_DELAY;
    i_addr = addr;
    i_ren  = 1'b1;
    @(negedge CLK);
    lat = 0;
    while (i_busy) begin
      @(negedge CLK);
      lat++;
    end
    rdata = i_rdata;
    @(posedge CLK);
    #DRIVE_DELAY;
    i_ren = 1'b0;
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("timeout, the DUT stopped completing transfers after %0d ns", WATCHDOG_NS);
    $display("Verification failed");
    $finish;
  end

  initial begin
    logic [31:0]       r;
    logic [ADDR_W-1:0] addr;
    logic [ADDR_W-1:0] iaddr;
    logic [DATA_W-1:0] wdata;
    logic [DATA_W-1:0] rdata;
    logic [DATA_W-1:0] irdata;
    logic [BE_W-1:0]   be;
    int                lat;
    int                ilat;
    int                d_seed;
    int                i_seed;
    seed = 32'hb9a0_058f;
    errors = 0;
    test_start_errors = 0;
    tests_passed = 0;
    tests_failed = 0;
    CLK = 1'b0;
    nRST = 1'b0;
    d_addr = '0;
    d_wdata = '0;
    d_byte_en = '0;
    d_ren = 1'b0;
    d_wen = 1'b0;
    i_addr = '0;
    i_ren = 1'b0;

    // test 1 checks busy around reset and then fills and spot reads the RAM
    @(negedge CLK);
    check_value("o_d_busy", 32'd1, 32'(d_busy));
    check_value("o_i_busy", 32'd1, 32'(i_busy));
    @(posedge CLK);
    #DRIVE_DELAY;
    nRST = 1'b1;
    @(negedge CLK);
    check_value("o_d_busy", 32'd1, 32'(d_busy));
    check_value("o_i_busy", 32'd1, 32'(i_busy));
    for (int i = 0; i < RAM_DEPTH_WORDS; i++) begin
      addr  = ADDR_W'(i) << 2;
      wdata = fill_word(addr);
      data_access(1'b1, addr, wdata, 4'hf, rdata, lat);
      model_write(addr, wdata, 4'hf);
    end
    for (int n = 0; n < N_CHECK; n++) begin
      r    = $random(seed);
      addr = {r[31:2], 2'b00};
      data_access(1'b0, addr, '0, 4'hf, rdata, lat);
      check_value("o_d_rdata", model_read(addr), rdata);
      check_value("data latency", BASE_LAT, lat);
    end
    finish_test("reset and fill");

    // test 2 reads full words back as written
    for (int n = 0; n < N_WORD; n++) begin
      r     = $random(seed);
      addr  = {r[31:2], 2'b00};
      wdata = $random(seed);
      data_access(1'b1, addr, wdata, 4'hf, rdata, lat);
      model_write(addr, wdata, 4'hf);
      data_access(1'b0, addr, '0, 4'hf, rdata, lat);
      check_value("o_d_rdata", wdata, rdata);
    end
    finish_test("full-word data path");

    // test 3 merges bytes and halfwords
    for (int n = 0; n < N_SUB; n++) begin
      r = $random(seed);
      case (r[2:0])
        3'd0: be = 4'b0001;
        3'd1: be = 4'b0010;
        3'd2: be = 4'b0100;
        3'd3: be = 4'b1000;
        3'd4: be = 4'b0011;
        3'd5: be = 4'b1100;
        default: be = 4'b1111;
      endcase
      addr  = {r[31:5], 3'b000, 2'b00};
      wdata = $random(seed);
      data_access(1'b1, addr, wdata, be, rdata, lat);
      model_write(addr, wdata, be);
      data_access(1'b0, addr, '0, 4'hf, rdata, lat);
      check_value("o_d_rdata", model_read(addr), rdata);
    end
    finish_test("byte and halfword writes");

    // test 4 fetches with a quiet data port
    for (int n = 0; n < N_INSTR; n++) begin
      r     = $random(seed);
      iaddr = {r[31:2], 2'b00};
      instr_access(iaddr, irdata, ilat);
      check_value("o_i_rdata", model_read(iaddr), irdata);
      check_value("instruction latency", BASE_LAT, ilat);
    end
    finish_test("instruction reads");

    // test 5 starts both ports together and then adds random contention
    for (int n = 0; n < N_SAME; n++) begin
      r     = $random(seed);
      addr  = {r[31:10], 1'b1, r[8:2], 2'b00};
      iaddr = {~r[31:10], 1'b0, r[9:3], 2'b00};
      fork
        data_access(1'b0, addr, '0, 4'hf, rdata, lat);
        instr_access(iaddr, irdata, ilat);
      join
      check_value("o_d_rdata", model_read(addr), rdata);
      check_value("o_i_rdata", model_read(iaddr), irdata);
      check_value("data latency", BASE_LAT, lat);
      check_value("instruction latency", 2 * BASE_LAT + 1, ilat);
    end
    d_seed = seed;
    i_seed = seed ^ 32'h1f2e_3d4c;
    // data stays in the upper half of the RAM and fetches in the lower half
    fork
      begin : data_side
        logic [31:0]       dr;
        logic [ADDR_W-1:0] da;
        logic [DATA_W-1:0] dw;
        logic [DATA_W-1:0] dq;
        int                dl;
        for (int n = 0; n < N_ARB; n++) begin
          dr = $random(d_seed);
          dw = $random(d_seed);
          da = {dr[31:10], 1'b1, dr[8:2], 2'b00};
          repeat (dr[1:0]) @(posedge CLK);
          if (dr[9]) begin
            data_access(1'b1, da, dw, 4'hf, dq, dl);
            model_write(da, dw, 4'hf);
          end else begin
            data_access(1'b0, da, '0, 4'hf, dq, dl);
            check_value("o_d_rdata", model_read(da), dq);
          end
        end
      end
      begin : instr_side
        logic [31:0]       ir;
        logic [ADDR_W-1:0] ia;
        logic [DATA_W-1:0] iq;
        int                il;
        for (int n = 0; n < N_ARB; n++) begin
          ir = $random(i_seed);
          ia = {ir[31:10], 1'b0, ir[8:2], 2'b00};
          repeat (ir[1:0]) @(posedge CLK);
          instr_access(ia, iq, il);
          check_value("o_i_rdata", model_read(ia), iq);
        end
      end
    join
    finish_test("arbitration");

    assert_errors = u_dut.u_ctrl.u_bus_checker.assert_fails;
    $display("tests passed: %0d, tests failed: %0d, assertion failures: %0d",
             tests_passed, tests_failed, assert_errors);
    if (errors == 0 && assert_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule
